/* src/lpif_pkg.sv */
////////////////////////////////////////////////////////////
// LPIF link shared definitions
// Widths, flit layout and receive sync states
////////////////////////////////////////////////////////////

`default_nettype none

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  // User data bus
  localparam int DATA_W = 64;

  // Flit after padding
  // Must divide evenly by 2, 4 and 8 lanes
  localparam int FLIT_W = 96;

  // Per-lane rolling sequence marker
  localparam int MRK_W = 2;

  // Bits taken by the user fields
  localparam int FLIT_USED_W = 4 + 2 + DATA_W + 1 + 16 + 1 + 1;

  // Zero fill up to the full flit
  localparam int FLIT_PAD_W = FLIT_W - FLIT_USED_W;

  ////////////////////////////////////////////////////////////
  // Types

  // One cycle of user fields
  // Pad sits at the top, valid at bit 0
  typedef struct packed {
    logic [FLIT_PAD_W-1:0] pad;
    logic [3:0]            state;
    logic [1:0]            protid;
    logic [DATA_W-1:0]     data;
    logic                  dvalid;
    // CRC carried through untouched
    logic [15:0]           crc;
    logic                  crc_valid;
    logic                  valid;
  } lpif_flit_t;

  // Receive online sequencing
  // Word alignment wait, then sync wait
  typedef enum logic [1:0] {
    SYNC_OFF,
    SYNC_WAIT_X,
    SYNC_WAIT_YZ,
    SYNC_ONLINE
  } lpif_sync_e;

endpackage

`default_nettype wire

/* src/lpif_auto_sync.sv */
////////////////////////////////////////////////////////////
// LPIF auto sync
// Holds off tx and rx online by programmable counts
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_auto_sync (
  input  logic       clk_wr,
  input  logic       rst,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  input  logic [7:0] delay_yz_value,
  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       stb_bit
);

  import lpif_pkg::*;

  logic [7:0] tx_cnt_q;
  logic       tx_online_q;

  lpif_sync_e rx_state_q;
  lpif_sync_e rx_state_d;
  logic [7:0] rx_cnt_q;
  logic [7:0] rx_cnt_d;

  ////////////////////////////////////////////////////////////
  // Transmit delay

  // Count cycles of tx_online, saturating
  // Online latches once the count reaches delay_xz_value
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_cnt_q    <= '0;
      tx_online_q <= 1'b0;
    end else if (!tx_online) begin
      // Drop straight away, restart the wait
      tx_cnt_q    <= '0;
      tx_online_q <= 1'b0;
    end else begin
      if (tx_cnt_q != 8'hff) begin
        tx_cnt_q <= tx_cnt_q + 8'd1;
      end
      if (tx_cnt_q >= delay_xz_value) begin
        tx_online_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive sync FSM

  // Down-counter loaded with count minus one
  // Zero counts skip their phase entirely
  always_comb begin
    rx_state_d = rx_state_q;
    rx_cnt_d   = rx_cnt_q;
    if (!rx_online) begin
      rx_state_d = SYNC_OFF;
      rx_cnt_d   = '0;
    end else begin
      case (rx_state_q)
        SYNC_OFF: begin
          if (delay_x_value != 8'd0) begin
            rx_state_d = SYNC_WAIT_X;
            rx_cnt_d   = delay_x_value - 8'd1;
          end else if (delay_yz_value != 8'd0) begin
            rx_state_d = SYNC_WAIT_YZ;
            rx_cnt_d   = delay_yz_value - 8'd1;
          end else begin
            rx_state_d = SYNC_ONLINE;
          end
        end
        SYNC_WAIT_X: begin
          // Word alignment time
          if (rx_cnt_q != 8'd0) begin
            rx_cnt_d = rx_cnt_q - 8'd1;
          end else if (delay_yz_value != 8'd0) begin
            rx_state_d = SYNC_WAIT_YZ;
            rx_cnt_d   = delay_yz_value - 8'd1;
          end else begin
            rx_state_d = SYNC_ONLINE;
          end
        end
        SYNC_WAIT_YZ: begin
          if (rx_cnt_q != 8'd0) begin
            rx_cnt_d = rx_cnt_q - 8'd1;
          end else begin
            rx_state_d = SYNC_ONLINE;
          end
        end
        default: begin
          // Stay online until rx_online drops
          rx_state_d = SYNC_ONLINE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_state_q <= SYNC_OFF;
      rx_cnt_q   <= '0;
    end else begin
      rx_state_q <= rx_state_d;
      rx_cnt_q   <= rx_cnt_d;
    end
  end

  // Outputs
  assign tx_online_delay = tx_online_q;
  // Persistent strobe follows the delayed tx online
  assign stb_bit         = tx_online_q;
  assign rx_online_delay = (rx_state_q == SYNC_ONLINE);

endmodule

`default_nettype wire

/* src/lpif_flit_pack.sv */
////////////////////////////////////////////////////////////
// LPIF flit pack and unpack
// Upstream fields into a flit, received flit onto dstrm
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_flit_pack (
  input  logic                        clk_wr,
  input  logic                        rst,
  input  logic [3:0]                  ustrm_state,
  input  logic [1:0]                  ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0] ustrm_data,
  input  logic                        ustrm_dvalid,
  input  logic [15:0]                 ustrm_crc,
  input  logic                        ustrm_crc_valid,
  input  logic                        ustrm_valid,
  output lpif_pkg::lpif_flit_t        tx_flit,
  input  lpif_pkg::lpif_flit_t        rx_flit,
  input  logic                        rx_flit_ok,
  output logic [3:0]                  dstrm_state,
  output logic [1:0]                  dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0] dstrm_data,
  output logic                        dstrm_dvalid,
  output logic [15:0]                 dstrm_crc,
  output logic                        dstrm_crc_valid,
  output logic                        dstrm_valid
);

  import lpif_pkg::*;

  lpif_flit_t tx_d;
  lpif_flit_t tx_q;
  lpif_flit_t dstrm_q;

  ////////////////////////////////////////////////////////////
  // Pack

  // Pad bits stay zero
  always_comb begin
    tx_d           = '0;
    tx_d.state     = ustrm_state;
    tx_d.protid    = ustrm_protid;
    tx_d.data      = ustrm_data;
    tx_d.dvalid    = ustrm_dvalid;
    tx_d.crc       = ustrm_crc;
    tx_d.crc_valid = ustrm_crc_valid;
    tx_d.valid     = ustrm_valid;
  end

  // Pack register, first stage toward the lanes
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_q <= '0;
    end else begin
      tx_q <= tx_d;
    end
  end

  assign tx_flit = tx_q;

  ////////////////////////////////////////////////////////////
  // Unpack

  // Blank the whole bus while the receiver is not online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      dstrm_q <= '0;
    end else if (rx_flit_ok) begin
      dstrm_q <= rx_flit;
    end else begin
      dstrm_q <= '0;
    end
  end

  assign dstrm_state     = dstrm_q.state;
  assign dstrm_protid    = dstrm_q.protid;
  assign dstrm_data      = dstrm_q.data;
  assign dstrm_dvalid    = dstrm_q.dvalid;
  assign dstrm_crc       = dstrm_q.crc;
  assign dstrm_crc_valid = dstrm_q.crc_valid;
  assign dstrm_valid     = dstrm_q.valid;

endmodule

`default_nettype wire

/* src/lpif_lane_tx.sv */
////////////////////////////////////////////////////////////
// LPIF lane transmit
// Stripes each flit over the lanes with strobe and marker
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_lane_tx #(
  parameter int LANES = 4
) (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  lpif_pkg::lpif_flit_t tx_flit,
  input  logic                 tx_online_delay,
  input  logic                 stb_bit,
  output logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] tx_phy,
  output logic [31:0]          flit_count
);

  import lpif_pkg::*;

  // Payload bits per lane
  localparam int SLICE_W = FLIT_W / LANES;

  // Lane word with strobe at the top
  typedef struct packed {
    logic               strobe;
    logic [MRK_W-1:0]   marker;
    logic [SLICE_W-1:0] payload;
  } lpif_lane_t;

  logic [MRK_W-1:0]       mrk_q;
  logic [FLIT_W-1:0]      flit_bits;
  lpif_lane_t [LANES-1:0] words_d;
  lpif_lane_t [LANES-1:0] words_q;
  logic [31:0]            sent_q;

  assign flit_bits = tx_flit;

  ////////////////////////////////////////////////////////////
  // Marker

  // Held at zero offline so the first online word carries 0
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      mrk_q <= '0;
    end else if (!tx_online_delay) begin
      mrk_q <= '0;
    end else begin
      mrk_q <= mrk_q + MRK_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Striping

  // Lane i carries slice i so lane 0 gets the low bits
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      words_d[i].strobe  = stb_bit;
      words_d[i].marker  = mrk_q;
      words_d[i].payload = flit_bits[i*SLICE_W +: SLICE_W];
    end
  end

  // Stripe register
  // Lanes idle at all zeros
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      words_q <= '0;
    end else if (tx_online_delay) begin
      words_q <= words_d;
    end else begin
      words_q <= '0;
    end
  end

  assign tx_phy = words_q;

  // Saturating count of sent valid flits
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      sent_q <= '0;
    end else if (tx_online_delay && tx_flit.valid && (sent_q != '1)) begin
      sent_q <= sent_q + 32'd1;
    end
  end

  assign flit_count = sent_q;

endmodule

`default_nettype wire

/* src/lpif_lane_rx.sv */
////////////////////////////////////////////////////////////
// LPIF lane receive
// Gathers lane words into a flit, checks strobe and marker
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_lane_rx #(
  parameter int LANES = 4
) (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] rx_phy,
  input  logic                 rx_online_delay,
  output lpif_pkg::lpif_flit_t rx_flit,
  output logic                 rx_flit_ok,
  output logic [31:0]          err_count
);

  import lpif_pkg::*;

  localparam int SLICE_W = FLIT_W / LANES;

  // Same layout as the transmit lane word
  typedef struct packed {
    logic               strobe;
    logic [MRK_W-1:0]   marker;
    logic [SLICE_W-1:0] payload;
  } lpif_lane_t;

  lpif_lane_t [LANES-1:0] words;
  logic [FLIT_W-1:0]      gather_d;
  lpif_flit_t             flit_q;
  logic                   ok_q;
  logic [MRK_W-1:0]       exp_mrk_q;
  logic                   exp_vld_q;
  logic                   lane_err;
  logic [31:0]            err_q;

  assign words = rx_phy;

  ////////////////////////////////////////////////////////////
  // Gather and check

  // Reassemble slices in lane order
  // Marker only checked once an expectation exists
  always_comb begin
    gather_d = '0;
    lane_err = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      gather_d[i*SLICE_W +: SLICE_W] = words[i].payload;
      if (!words[i].strobe) begin
        lane_err = 1'b1;
      end
      if (exp_vld_q && (words[i].marker != exp_mrk_q)) begin
        lane_err = 1'b1;
      end
    end
  end

  // Gather register
  // Payload forwarded even on error
  always_ff @(posedge clk_wr) begin
    flit_q <= gather_d;
  end

  // First online word seeds the expected marker from lane 0
  // Free-running after that so one bad word costs one error
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ok_q      <= 1'b0;
      exp_vld_q <= 1'b0;
      exp_mrk_q <= '0;
    end else begin
      ok_q <= rx_online_delay;
      if (!rx_online_delay) begin
        exp_vld_q <= 1'b0;
        exp_mrk_q <= '0;
      end else if (!exp_vld_q) begin
        exp_vld_q <= 1'b1;
        exp_mrk_q <= words[0].marker + MRK_W'(1);
      end else begin
        exp_mrk_q <= exp_mrk_q + MRK_W'(1);
      end
    end
  end

  // Saturating count of error cycles while online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      err_q <= '0;
    end else if (rx_online_delay && lane_err && (err_q != '1)) begin
      err_q <= err_q + 32'd1;
    end
  end

  assign rx_flit    = flit_q;
  assign rx_flit_ok = ok_q;
  assign err_count  = err_q;

endmodule

`default_nettype wire

/* src/lpif_link_top.sv */
////////////////////////////////////////////////////////////
// LPIF slave link top
// Auto sync, flit pack, lane transmit and lane receive
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_link_top #(
  parameter int LANES = 4
) (
  input  logic                        clk_wr,
  input  logic                        rst,
  // Control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [7:0]                  delay_x_value,
  input  logic [7:0]                  delay_xz_value,
  input  logic [7:0]                  delay_yz_value,
  // PHY lanes
  output logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] tx_phy,
  input  logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] rx_phy,
  // Downstream user bus
  output logic [3:0]                  dstrm_state,
  output logic [1:0]                  dstrm_protid,
  output logic [lpif_pkg::DATA_W-1:0] dstrm_data,
  output logic                        dstrm_dvalid,
  output logic [15:0]                 dstrm_crc,
  output logic                        dstrm_crc_valid,
  output logic                        dstrm_valid,
  // Upstream user bus
  input  logic [3:0]                  ustrm_state,
  input  logic [1:0]                  ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0] ustrm_data,
  input  logic                        ustrm_dvalid,
  input  logic [15:0]                 ustrm_crc,
  input  logic                        ustrm_crc_valid,
  input  logic                        ustrm_valid,
  // Debug
  output logic [31:0]                 rx_downstream_debug_status,
  output logic [31:0]                 tx_upstream_debug_status
);

  import lpif_pkg::*;

  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;
  logic       rx_flit_ok;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       stb_bit;

  ////////////////////////////////////////////////////////////
  // Auto sync
  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_bit         (stb_bit)
  );

  ////////////////////////////////////////////////////////////
  // User side
  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .rx_flit_ok      (rx_flit_ok),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // PHY side
  lpif_lane_tx #(
    .LANES (LANES)
  ) lpif_lane_tx_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .stb_bit         (stb_bit),
    .tx_phy          (tx_phy),
    .flit_count      (tx_upstream_debug_status)
  );

  lpif_lane_rx #(
    .LANES (LANES)
  ) lpif_lane_rx_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .rx_phy          (rx_phy),
    .rx_online_delay (rx_online_delay),
    .rx_flit         (rx_flit),
    .rx_flit_ok      (rx_flit_ok),
    .err_count       (rx_downstream_debug_status)
  );

endmodule

`default_nettype wire

/* tests/lpif_link_checker.sv */
////////////////////////////////////////////////////////////
// LPIF link checker
// Cycle model of sync delays, lane pipeline and markers
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_link_checker #(
  parameter int LANES = 4
) (
  input  logic                        clk_wr,
  input  logic                        rst,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [7:0]                  delay_x_value,
  input  logic [7:0]                  delay_xz_value,
  input  logic [7:0]                  delay_yz_value,
  input  logic [3:0]                  ustrm_state,
  input  logic [1:0]                  ustrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0] ustrm_data,
  input  logic                        ustrm_dvalid,
  input  logic [15:0]                 ustrm_crc,
  input  logic                        ustrm_crc_valid,
  input  logic                        ustrm_valid,
  input  logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] inj_mask,
  input  logic [LANES*(1+lpif_pkg::MRK_W+lpif_pkg::FLIT_W/LANES)-1:0] tx_phy,
  input  logic [3:0]                  dstrm_state,
  input  logic [1:0]                  dstrm_protid,
  input  logic [lpif_pkg::DATA_W-1:0] dstrm_data,
  input  logic                        dstrm_dvalid,
  input  logic [15:0]                 dstrm_crc,
  input  logic                        dstrm_crc_valid,
  input  logic                        dstrm_valid,
  input  logic [31:0]                 rx_downstream_debug_status,
  input  logic [31:0]                 tx_upstream_debug_status,
  output int                          checks,
  output int                          errors
);

  import lpif_pkg::*;

  localparam int SLICE_W = FLIT_W / LANES;
  localparam int WORD_W  = 1 + MRK_W + SLICE_W;
  localparam int PHY_W   = LANES * WORD_W;

  // Inputs seen last cycle, taken by the coming edge
  logic             rst_q   = 1'b1;
  logic             tx_on_q = 1'b0;
  logic             rx_on_q = 1'b0;
  logic [7:0]       dx_q    = '0;
  logic [7:0]       dxz_q   = '0;
  logic [7:0]       dyz_q   = '0;
  lpif_flit_t       u_q     = '0;
  // Lane words the receiver saw, faults included
  logic [PHY_W-1:0] rxw_q   = '0;

  // History, index 0 is the newest edge
  lpif_flit_t [3:0] u_h   = '0;
  logic [3:0]       txd_h = '0;
  logic [3:0]       rxd_h = '0;

  int               tx_run  = 0;
  int               rx_run  = 0;
  logic [MRK_W-1:0] mrk     = '0;
  logic [MRK_W-1:0] exp_mrk = '0;
  logic             exp_vld = 1'b0;
  logic [31:0]      tx_cnt  = '0;
  logic [31:0]      rx_cnt  = '0;
  logic [PHY_W-1:0] exp_phy = '0;
  lpif_flit_t       exp_d;
  logic             lane_err;
  logic [WORD_W-1:0] w;
  int               n_chk = 0;
  int               n_err = 0;

  assign checks = n_chk;
  assign errors = n_err;

  // Lane i gets slice i, strobe on top, then marker
  function automatic logic [PHY_W-1:0] stripe(input lpif_flit_t f, input logic [MRK_W-1:0] mk);
    logic [FLIT_W-1:0] bits;
    logic [PHY_W-1:0]  v;
    bits = f;
    v    = '0;
    for (int i = 0; i < LANES; i++) begin
      v[i*WORD_W +: WORD_W] = {1'b1, mk, bits[i*SLICE_W +: SLICE_W]};
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] want);
    n_chk++;
    if (got !== want) begin
      n_err++;
      $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model step and compare, at the falling edge

  always @(negedge clk_wr) begin
    u_h   = {u_h[2:0], u_q};
    txd_h = {txd_h[2:0], 1'b0};
    rxd_h = {rxd_h[2:0], 1'b0};
    if (rst_q) begin
      tx_run  = 0;
      rx_run  = 0;
      mrk     = '0;
      exp_vld = 1'b0;
      exp_mrk = '0;
      tx_cnt  = '0;
      rx_cnt  = '0;
      exp_phy = '0;
    end else begin
      // Receive check on last cycle's lane words
      if (rxd_h[1]) begin
        lane_err = 1'b0;
        for (int i = 0; i < LANES; i++) begin
          w = rxw_q[i*WORD_W +: WORD_W];
          if (!w[WORD_W-1]) begin
            lane_err = 1'b1;
          end
          if (exp_vld && (w[WORD_W-2 -: MRK_W] != exp_mrk)) begin
            lane_err = 1'b1;
          end
        end
        if (lane_err && (rx_cnt != '1)) begin
          rx_cnt++;
        end
        // First online word sets the expectation
        if (!exp_vld) begin
          exp_vld = 1'b1;
          exp_mrk = rxw_q[WORD_W-2 -: MRK_W] + 2'd1;
        end else begin
          exp_mrk = exp_mrk + 2'd1;
        end
      end else begin
        exp_vld = 1'b0;
        exp_mrk = '0;
      end
      // Sync delays from runs of consecutive high samples
      tx_run   = tx_on_q ? tx_run + 1 : 0;
      rx_run   = rx_on_q ? rx_run + 1 : 0;
      txd_h[0] = (tx_run >= int'(dxz_q) + 1);
      rxd_h[0] = (rx_run >= int'(dx_q) + int'(dyz_q) + 1);
      // Lane words, marker restarts at 0 each online run
      if (txd_h[1]) begin
        mrk     = txd_h[2] ? mrk + 2'd1 : '0;
        exp_phy = stripe(u_h[1], mrk);
        if (u_h[1].valid && (tx_cnt != '1)) begin
          tx_cnt++;
        end
      end else begin
        exp_phy = '0;
      end
    end
    // Four cycles from ustrm to dstrm
    exp_d = (rxd_h[2] && txd_h[3]) ? u_h[3] : '0;
    if (!rst_q) begin
      compare("tx_phy", 128'(tx_phy), 128'(exp_phy));
      compare("dstrm_valid", 128'(dstrm_valid), 128'(exp_d.valid));
      compare("dstrm_state", 128'(dstrm_state), 128'(exp_d.state));
      compare("dstrm_protid", 128'(dstrm_protid), 128'(exp_d.protid));
      compare("dstrm_data", 128'(dstrm_data), 128'(exp_d.data));
      compare("dstrm_dvalid", 128'(dstrm_dvalid), 128'(exp_d.dvalid));
      compare("dstrm_crc", 128'(dstrm_crc), 128'(exp_d.crc));
      compare("dstrm_crc_valid", 128'(dstrm_crc_valid), 128'(exp_d.crc_valid));
      compare("tx_upstream_debug_status", 128'(tx_upstream_debug_status), 128'(tx_cnt));
      compare("rx_downstream_debug_status", 128'(rx_downstream_debug_status), 128'(rx_cnt));
    end
    // Capture inputs for the next edge
    rst_q           = rst;
    tx_on_q         = tx_online;
    rx_on_q         = rx_online;
    dx_q            = delay_x_value;
    dxz_q           = delay_xz_value;
    dyz_q           = delay_yz_value;
    u_q             = '0;
    u_q.state       = ustrm_state;
    u_q.protid      = ustrm_protid;
    u_q.data        = ustrm_data;
    u_q.dvalid      = ustrm_dvalid;
    u_q.crc         = ustrm_crc;
    u_q.crc_valid   = ustrm_crc_valid;
    u_q.valid       = ustrm_valid;
    rxw_q           = exp_phy ^ inj_mask;
  end

endmodule

`default_nettype wire

/* tests/lpif_link_tb.sv */
////////////////////////////////////////////////////////////
// LPIF link testbench
// Random user traffic over looped back lanes, marker faults
////////////////////////////////////////////////////////////

`default_nettype none

module lpif_link_tb;

  import lpif_pkg::*;

  localparam int LANES  = 4;
  localparam int WORD_W = 1 + MRK_W + FLIT_W / LANES;
  localparam int PHY_W  = LANES * WORD_W;

  // Test lengths in cycles
  localparam int RESET_CYC   = 5;
  localparam int IDLE_MAX    = 47;
  localparam int WAIT_MAX    = 64;
  localparam int SYNC_CYC    = 40;
  localparam int STREAM_CYC  = 400;
  localparam int INJECT_CYC  = 300;
  localparam int RESTART_CYC = 60;
  localparam int WATCHDOG_CYC = RESET_CYC + IDLE_MAX + 4 * (WAIT_MAX + 1) + SYNC_CYC
                              + STREAM_CYC + INJECT_CYC + 12 + RESTART_CYC + 100;

  logic                clk_wr;
  logic                rst;
  logic                tx_online;
  logic                rx_online;
  logic [7:0]          delay_x_value;
  logic [7:0]          delay_xz_value;
  logic [7:0]          delay_yz_value;
  logic [3:0]          ustrm_state;
  logic [1:0]          ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic                ustrm_dvalid;
  logic [15:0]         ustrm_crc;
  logic                ustrm_crc_valid;
  logic                ustrm_valid;
  logic [3:0]          dstrm_state;
  logic [1:0]          dstrm_protid;
  logic [DATA_W-1:0]   dstrm_data;
  logic                dstrm_dvalid;
  logic [15:0]         dstrm_crc;
  logic                dstrm_crc_valid;
  logic                dstrm_valid;
  logic [PHY_W-1:0]    tx_phy;
  logic [PHY_W-1:0]    rx_phy;
  logic [PHY_W-1:0]    inj_mask;
  logic [31:0]         rx_dbg;
  logic [31:0]         tx_dbg;
  int                  checks;
  int                  errors;

  integer seed = 32'h5f9f;
  int tb_fail = 0;
  int n_inj = 0;
  int last_chk = 0;
  int last_err = 0;

  // Lane loopback with optional marker fault
  assign rx_phy = tx_phy ^ inj_mask;

  lpif_link_top #(
    .LANES (LANES)
  ) dut0 (
    .clk_wr (clk_wr), .rst (rst), .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_xz_value (delay_xz_value),
    .delay_yz_value (delay_yz_value), .tx_phy (tx_phy), .rx_phy (rx_phy),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .rx_downstream_debug_status (rx_dbg), .tx_upstream_debug_status (tx_dbg)
  );

  lpif_link_checker #(
    .LANES (LANES)
  ) chk_i (
    .clk_wr (clk_wr), .rst (rst), .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_xz_value (delay_xz_value),
    .delay_yz_value (delay_yz_value), .ustrm_state (ustrm_state),
    .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data), .ustrm_dvalid (ustrm_dvalid),
    .ustrm_crc (ustrm_crc), .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .inj_mask (inj_mask), .tx_phy (tx_phy), .dstrm_state (dstrm_state),
    .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data), .dstrm_dvalid (dstrm_dvalid),
    .dstrm_crc (dstrm_crc), .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .rx_downstream_debug_status (rx_dbg), .tx_upstream_debug_status (tx_dbg),
    .checks (checks), .errors (errors)
  );

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYC * 4);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYC);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks

  // One cycle of random upstream fields, fault on 1 in 8 cycles
  task automatic step(input bit inject);
    logic [31:0]      r0;
    logic [31:0]      r1;
    logic [31:0]      r2;
    logic [PHY_W-1:0] mask;
    int               lane;
    @(posedge clk_wr);
    r0   = $random(seed);
    r1   = $random(seed);
    r2   = $random(seed);
    mask = '0;
    if (inject && (r0[11:9] == 3'd0)) begin
      lane = int'(r0[14:12]) % LANES;
      // Marker bit 0 of the chosen lane
      mask[lane*WORD_W + WORD_W - 1 - MRK_W] = 1'b1;
      n_inj++;
    end
    ustrm_state     <= r0[3:0];
    ustrm_protid    <= r0[5:4];
    ustrm_dvalid    <= r0[6];
    ustrm_crc_valid <= r0[7];
    ustrm_valid     <= r0[8];
    ustrm_crc       <= r0[31:16];
    ustrm_data      <= {r1, r2};
    inj_mask        <= mask;
  endtask

  task automatic run_cycles(input int n, input bit inject);
    repeat (n) step(inject);
  endtask

  task automatic release_reset();
    rst <= 1'b0;
  endtask

  task automatic set_online(input logic tx, input logic rx);
    tx_online <= tx;
    rx_online <= rx;
  endtask

  // Small random sync counts
  task automatic set_delays();
    logic [31:0] r;
    r = $random(seed);
    delay_x_value  <= {5'd0, r[2:0]};
    delay_yz_value <= {5'd0, r[5:3]};
    delay_xz_value <= {5'd0, r[8:6]};
  endtask

  // Wait for lane traffic or for dstrm_valid, bounded
  task automatic wait_up(input bit for_rx, input string name);
    int n;
    bit up;
    n  = 0;
    up = 1'b0;
    while (!up && (n < WAIT_MAX)) begin
      step(1'b0);
      @(negedge clk_wr);
      up = for_rx ? dstrm_valid : (tx_phy != '0);
      n++;
    end
    if (!up) begin
      tb_fail++;
      $display("Test %s: %s side did not come online within %0d cycles",
               name, for_rx ? "receive" : "transmit", WAIT_MAX);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %-8s %0d checks, %0d errors", name, checks - last_chk,
             errors - last_err);
    last_chk = checks;
    last_err = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_x_value = '0;
    delay_xz_value = '0;
    delay_yz_value = '0;
    ustrm_state = '0;
    ustrm_protid = '0;
    ustrm_data = '0;
    ustrm_dvalid = 1'b0;
    ustrm_crc = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid = 1'b0;
    inj_mask = '0;
    repeat (RESET_CYC) @(posedge clk_wr);
    release_reset();
    // Offline traffic must not leak out
    run_cycles(32 + ($unsigned($random(seed)) % 16), 1'b0);
    report_test("idle");
    // Transmit first so the receiver seeds on real markers
    set_delays();
    set_online(1'b1, 1'b0);
    wait_up(1'b0, "sync");
    step(1'b0);
    set_online(1'b1, 1'b1);
    wait_up(1'b1, "sync");
    run_cycles(SYNC_CYC, 1'b0);
    report_test("sync");
    run_cycles(STREAM_CYC, 1'b0);
    report_test("stream");
    run_cycles(INJECT_CYC, 1'b1);
    $display("Marker faults injected on %0d cycles", n_inj);
    report_test("inject");
    // Drop and bring back the link
    set_online(1'b0, 1'b1);
    run_cycles(8, 1'b0);
    set_online(1'b0, 1'b0);
    run_cycles(4, 1'b0);
    set_online(1'b1, 1'b0);
    wait_up(1'b0, "restart");
    step(1'b0);
    set_online(1'b1, 1'b1);
    wait_up(1'b1, "restart");
    run_cycles(RESTART_CYC, 1'b0);
    report_test("restart");
    $display("Total: %0d checks, %0d errors", checks, errors + tb_fail);
    if ((errors == 0) && (tb_fail == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/lpif_pkg.sv
src/lpif_auto_sync.sv
src/lpif_flit_pack.sv
src/lpif_lane_tx.sv
src/lpif_lane_rx.sv
src/lpif_link_top.sv
tests/lpif_link_checker.sv
tests/lpif_link_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the LPIF link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 -f src.f --top-module lpif_link_tb -o lpif_link_sim > build.log 2>&1 \
  && ./obj_dir/lpif_link_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -qx "Finished with no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
